// File: dv/l2_localmem_input.txt
# op test set way line tag hprot state evict, hex except test; P put L line S state I init_all
# E evict R read W read with put; X after R/W: line0-3 tag0-3 hprot0-3 state0-3 evict
P 1 05 0 1000000000000050 050 0 1 0
P 1 05 1 1111 051 1 2 0
P 1 05 2 2222 052 0 3 0
P 1 05 3 3333 053 1 4 0
E 1 05 0 0 000 0 0 2
R 1 05 0 0 000 0 0 0
X 1000000000000050 1111 2222 3333 050 051 052 053 0 1 0 1 1 2 3 4 2
P 1 05 2 a5a5a5a5a5a5a5a5 3ff 1 7 0
R 1 05 0 0 000 0 0 0
X 1000000000000050 1111 a5a5a5a5a5a5a5a5 3333 050 051 3ff 053 0 1 1 1 1 2 7 4 2
L 2 05 1 beef 2aa 0 5 3
R 2 05 0 0 000 0 0 0
X 1000000000000050 beef a5a5a5a5a5a5a5a5 3333 050 051 3ff 053 0 1 1 1 1 2 7 4 2
S 2 05 3 dead 111 0 6 3
R 2 05 0 0 000 0 0 0
X 1000000000000050 beef a5a5a5a5a5a5a5a5 3333 050 051 3ff 053 0 1 1 1 1 2 7 6 2
P 3 0c 0 c0 0c0 1 1 0
P 3 0c 1 c1 0c1 0 2 0
P 3 0c 2 c2 0c2 1 3 0
P 3 0c 3 c3 0c3 0 4 0
E 3 0c 2 0 000 0 0 1
I 3 0c 2 ffff 3ff 1 5 0
R 3 0c 0 0 000 0 0 0
X c0 c1 c2 c3 0c0 0c1 0c2 0c3 1 0 1 0 5 5 5 5 1
R 3 05 0 0 000 0 0 0
X 1000000000000050 beef a5a5a5a5a5a5a5a5 3333 050 051 3ff 053 0 1 1 1 1 2 7 6 2
E 4 0c 1 0 000 0 0 3
E 4 05 0 0 000 0 0 1
R 4 0c 0 0 000 0 0 0
X c0 c1 c2 c3 0c0 0c1 0c2 0c3 1 0 1 0 5 5 5 5 3
R 4 05 0 0 000 0 0 0
X 1000000000000050 beef a5a5a5a5a5a5a5a5 3333 050 051 3ff 053 0 1 1 1 1 2 7 6 1
P 5 25 0 2500000000000000 250 1 1 0
P 5 25 1 2511 251 1 1 0
P 5 25 2 2522 252 0 2 0
P 5 25 3 2533 253 0 2 0
E 5 25 0 0 000 0 0 3
R 5 25 0 0 000 0 0 0
X 2500000000000000 2511 2522 2533 250 251 252 253 1 1 0 0 1 1 2 2 3
R 5 05 0 0 000 0 0 0
X 1000000000000050 beef a5a5a5a5a5a5a5a5 3333 050 051 3ff 053 0 1 1 1 1 2 7 6 1
R 5 25 0 0 000 0 0 0
X 2500000000000000 2511 2522 2533 250 251 252 253 1 1 0 0 1 1 2 2 3
W 6 0c 0 600d 3c0 0 3 0
X c0 c1 c2 c3 0c0 0c1 0c2 0c3 1 0 1 0 5 5 5 5 3
R 6 0c 0 0 000 0 0 0
X 600d c1 c2 c3 3c0 0c1 0c2 0c3 0 0 1 0 3 5 5 5 3

// File: dv/l2_localmem_tb.sv
/* L2 local memory testbench
   replays the operation records of the data file and checks every read */
module l2_localmem_tb;

    import cache_types_pkg::*;

    typedef struct packed {
        logic [7:0]        op;
        logic [15:0]       test;
        set_t              set_idx;
        way_t              way;
        line_t             line;
        tag_t              tag;
        hprot_t            hprot;
        state_t            state;
        way_t              ptr;
        line_t [WAYS-1:0]  exp_line;
        tag_t [WAYS-1:0]   exp_tag;
        logic [WAYS-1:0]   exp_hprot;
        state_t [WAYS-1:0] exp_state;
        way_t              exp_ptr;
    } rec_t;

    logic   clk;
    logic   wr_rst;
    logic   rd_en;
    set_t   set_in;
    way_t   way;
    logic   wr_en_line;
    logic   wr_en_state;
    logic   wr_en_evict_way;
    logic   wr_en_put_reqs;
    logic   init_all;
    line_t  wr_data_line;
    tag_t   wr_data_tag;
    hprot_t wr_data_hprot;
    state_t wr_data_state;
    way_t   wr_data_evict_way;
    line_t  rd_data_line [WAYS];
    tag_t   rd_data_tag [WAYS];
    hprot_t rd_data_hprot [WAYS];
    state_t rd_data_state [WAYS];
    way_t   rd_data_evict_way;

    rec_t recs [$];
    rec_t pend_rec;
    rec_t chk_rec;
    logic pend = 1'b0;
    logic chk = 1'b0;
    int   cycles = 0;
    int   cycle_limit = 0;
    int   test_errs = 0;
    int   err_cnt = 0;
    int   tests_passed = 0;
    int   tests_failed = 0;

    tb_clkgen #(.PERIOD(8), .RST_CYCLES(2)) clkgen_i (.clk(clk), .wr_rst(wr_rst));

    l2_localmem l2_localmem_i (.*);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Error: run timed out after %0d cycles", cycles);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic logic is_read(input rec_t r);
        return (r.op == "R") || (r.op == "W");
    endfunction

    task automatic load_records(output logic ok);
        int     fd;
        int     n;
        int     t;
        string  text;
        logic [7:0] op;
        set_t   s;
        way_t   w;
        line_t  ln;
        tag_t   tg;
        hprot_t hp;
        state_t st;
        way_t   pt;
        line_t  el [WAYS];
        tag_t   et [WAYS];
        hprot_t eh [WAYS];
        state_t es [WAYS];
        way_t   ep;
        rec_t   r;
        logic   waiting;
        ok = 1'b1;
        waiting = 1'b0;
        r = '0;
        fd = $fopen("dv/l2_localmem_input.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open dv/l2_localmem_input.txt");
            ok = 1'b0;
            return;
        end
        while ($fgets(text, fd) > 0) begin
            if ($sscanf(text, " %c", op) != 1 || op == "#") begin
                continue;
            end
            if (op == "X") begin
                n = $sscanf(text, " %c %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    op, el[0], el[1], el[2], el[3], et[0], et[1], et[2], et[3],
                    eh[0], eh[1], eh[2], eh[3], es[0], es[1], es[2], es[3], ep);
                if (!waiting || n != 18) begin
                    $display("Error: stray or short expected-value line: %s", text);
                    ok = 1'b0;
                end else begin
                    for (int i = 0; i < WAYS; i++) begin
                        r.exp_line[i] = el[i];
                        r.exp_tag[i] = et[i];
                        r.exp_hprot[i] = eh[i];
                        r.exp_state[i] = es[i];
                    end
                    r.exp_ptr = ep;
                    recs.push_back(r);
                    waiting = 1'b0;
                end
            end else begin
                n = $sscanf(text, " %c %d %h %h %h %h %h %h %h", op, t, s, w, ln, tg, hp, st, pt);
                if (waiting || n != 9 || !(op inside {"P", "L", "S", "I", "E", "R", "W"})) begin
                    $display("Error: bad record or read without expected values: %s", text);
                    ok = 1'b0;
                end
                r = '0;
                r.op = op;
                r.test = 16'(t);
                r.set_idx = s;
                r.way = w;
                r.line = ln;
                r.tag = tg;
                r.hprot = hp;
                r.state = st;
                r.ptr = pt;
                waiting = is_read(r);
                if (!waiting) begin
                    recs.push_back(r);
                end
            end
        end
        $fclose(fd);
        if (waiting) begin
            $display("Error: data file ends inside a read record");
            ok = 1'b0;
        end
    endtask

    task automatic drive_idle();
        rd_en = 1'b0;
        wr_en_line = 1'b0;
        wr_en_state = 1'b0;
        wr_en_evict_way = 1'b0;
        wr_en_put_reqs = 1'b0;
        init_all = 1'b0;
    endtask

    task automatic drive_record(input rec_t r);
        drive_idle();
        set_in = r.set_idx;
        way = r.way;
        wr_data_line = r.line;
        wr_data_tag = r.tag;
        wr_data_hprot = r.hprot;
        wr_data_state = r.state;
        wr_data_evict_way = r.ptr;
        case (r.op)
            "P": wr_en_put_reqs = 1'b1;
            "L": wr_en_line = 1'b1;
            "S": wr_en_state = 1'b1;
            "I": init_all = 1'b1;
            "E": wr_en_evict_way = 1'b1;
            "R": rd_en = 1'b1;
            "W": begin
                rd_en = 1'b1;
                wr_en_put_reqs = 1'b1;
            end
            default: begin
            end
        endcase
    endtask

    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        assert (act === exp) else begin
            $display("Mismatch at %0t: %s expected %0h got %0h", $time, name, exp, act);
            test_errs++;
        end
    endtask

    task automatic check_read(input rec_t r);
        for (int w = 0; w < WAYS; w++) begin
            compare($sformatf("rd_data_line[%0d]", w), r.exp_line[w], rd_data_line[w]);
            compare($sformatf("rd_data_tag[%0d]", w), 64'(r.exp_tag[w]), 64'(rd_data_tag[w]));
            compare($sformatf("rd_data_hprot[%0d]", w), 64'(r.exp_hprot[w]),
                64'(rd_data_hprot[w]));
            compare($sformatf("rd_data_state[%0d]", w), 64'(r.exp_state[w]),
                64'(rd_data_state[w]));
        end
        compare("rd_data_evict_way", 64'(r.exp_ptr), 64'(rd_data_evict_way));
    endtask

    // read data of the last edge is checked at the falling edge, after the set has moved on
    task automatic next_cycle();
        @(negedge clk);
        if (chk) begin
            check_read(chk_rec);
            chk = 1'b0;
        end
        @(posedge clk);
        #1;
        chk = pend;
        chk_rec = pend_rec;
        pend = 1'b0;
    endtask

    task automatic report_test(input int t);
        if (test_errs == 0) begin
            $display("test %0d passed", t);
            tests_passed++;
        end else begin
            $display("test %0d failed with %0d errors", t, test_errs);
            tests_failed++;
        end
        err_cnt += test_errs;
        test_errs = 0;
    endtask

    initial begin
        logic ok;
        int   gap;
        int   cur_test;
        logic prev_rd;
        void'($urandom(88));
        drive_idle();
        set_in = '0;
        way = '0;
        wr_data_line = '0;
        wr_data_tag = '0;
        wr_data_hprot = 1'b0;
        wr_data_state = '0;
        wr_data_evict_way = '0;
        load_records(ok);
        if (!ok || recs.size() == 0) begin
            $display("Error: the data file holds no usable records");
            $display("Finished with errors");
            $finish;
        end else begin
            cycle_limit = 4 * recs.size() + 50;
            wait (wr_rst == 1'b0);
            prev_rd = 1'b0;
            cur_test = int'(recs[0].test);
            foreach (recs[i]) begin
                if (int'(recs[i].test) != cur_test) begin
                    // last read of the finished test is checked before its report
                    drive_idle();
                    next_cycle();
                    report_test(cur_test);
                    cur_test = int'(recs[i].test);
                end
                // consecutive reads in the file go out on consecutive cycles
                if (!(prev_rd && is_read(recs[i]))) begin
                    gap = $urandom_range(3, 0);
                    drive_idle();
                    repeat (gap) next_cycle();
                end
                drive_record(recs[i]);
                pend_rec = recs[i];
                pend = is_read(recs[i]);
                prev_rd = is_read(recs[i]);
                next_cycle();
            end
            drive_idle();
            next_cycle();
            report_test(cur_test);
            $display("tests passed %0d, failed %0d, mismatches %0d",
                tests_passed, tests_failed, err_cnt);
            if (err_cnt == 0 && tests_failed == 0) begin
                $display("Finished with no errors");
            end else begin
                $display("Finished with errors");
            end
            $finish;
        end
    end

endmodule

// File: dv/tb_clkgen.sv
/* testbench clock and reset generator */
module tb_clkgen #(
    parameter int PERIOD = 8,
    parameter int RST_CYCLES = 2
) (
    output logic clk,
    output logic wr_rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // released just after an edge, like the other inputs
    initial begin
        wr_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #1 wr_rst = 1'b0;
    end

endmodule

// File: l2_localmem.f
+incdir+src
src/cache_types_pkg.sv
src/l2_bank_pkg.sv
src/l2_sync_sram.sv
src/l2_field_array.sv
src/l2_wr_decode.sv
src/l2_localmem.sv
dv/tb_clkgen.sv
dv/l2_localmem_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the L2 local memory testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module l2_localmem_tb \
    -f l2_localmem.f \
    -o sim_l2_localmem

./obj_dir/sim_l2_localmem | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: src/cache_types_pkg.sv
/* cache field types
   set index, way number and the per-way fields held in the L2 local memory */
`include "l2_mem_cfg.svh"

package cache_types_pkg;

    localparam int WAYS = `L2_WAYS;
    localparam int SET_BITS = `L2_SET_BITS;
    // at least one bit even for a direct-mapped cache
    localparam int WAY_BITS = (WAYS > 1) ? $clog2(WAYS) : 1;

    typedef logic [SET_BITS-1:0] set_t;
    typedef logic [WAY_BITS-1:0] way_t;

    typedef logic [`L2_LINE_BITS-1:0] line_t;
    typedef logic [`L2_TAG_BITS-1:0] tag_t;
    typedef logic [`L2_STATE_BITS-1:0] state_t;
    typedef logic hprot_t;

    // one bit per way, used for write enables
    typedef logic [WAYS-1:0] way_vec_t;

endpackage

// File: src/l2_bank_pkg.sv
/* bank geometry of the L2 local memory
   bank counts, bank index widths and bank index types per field */
`include "l2_mem_cfg.svh"

package l2_bank_pkg;

    // a single bank still gets a one bit index
    function automatic int idx_bits(input int banks);
        return (banks > 1) ? $clog2(banks) : 1;
    endfunction

    localparam int LINE_BANKS = `L2_LINE_BANKS;
    localparam int TAG_BANKS = `L2_TAG_BANKS;
    localparam int STATE_BANKS = `L2_STATE_BANKS;
    localparam int HPROT_BANKS = `L2_HPROT_BANKS;
    localparam int EVICT_BANKS = `L2_EVICT_BANKS;

    localparam int LINE_BANK_BITS = idx_bits(LINE_BANKS);
    localparam int TAG_BANK_BITS = idx_bits(TAG_BANKS);
    localparam int STATE_BANK_BITS = idx_bits(STATE_BANKS);
    localparam int HPROT_BANK_BITS = idx_bits(HPROT_BANKS);
    localparam int EVICT_BANK_BITS = idx_bits(EVICT_BANKS);

    typedef logic [LINE_BANK_BITS-1:0] line_bank_t;
    typedef logic [TAG_BANK_BITS-1:0] tag_bank_t;
    typedef logic [STATE_BANK_BITS-1:0] state_bank_t;
    typedef logic [HPROT_BANK_BITS-1:0] hprot_bank_t;
    typedef logic [EVICT_BANK_BITS-1:0] evict_bank_t;

endpackage

// File: src/l2_field_array.sv
/* one cache field across all ways and set banks
   bank write select from the top set bits and read steering by the registered bank index */
module l2_field_array #(
    parameter int WIDTH = 8,
    parameter int WAYS = 1,
    parameter int BANKS = 1
) (
    input  logic                    clk,
    input  logic                    wr_rst,
    input  logic                    rd_en,
    input  cache_types_pkg::set_t   set_in,
    input  logic [WAYS-1:0]         we,
    input  logic [WIDTH-1:0]        wdata,
    output logic [WIDTH-1:0]        rdata [WAYS]
);

    import cache_types_pkg::*;
    import l2_bank_pkg::*;

    localparam int BANK_BITS = idx_bits(BANKS);
    localparam int ADDR_BITS = SET_BITS - $clog2(BANKS);
    localparam int DEPTH = 1 << ADDR_BITS;

    logic [BANK_BITS-1:0] bank_sel;
    logic [BANK_BITS-1:0] bank_q;
    logic [ADDR_BITS-1:0] bank_addr;
    logic [BANKS-1:0]     bank_dec;
    logic [WIDTH-1:0]     bank_rdata [WAYS][BANKS];

    if (BANKS > 1) begin : g_bank_idx
        assign bank_sel = set_in[SET_BITS-1 -: BANK_BITS];
    end else begin : g_one_bank
        assign bank_sel = '0;
    end

    // lower set bits address the word inside a bank
    assign bank_addr = set_in[ADDR_BITS-1:0];

    always_comb begin
        for (int b = 0; b < BANKS; b++) begin
            bank_dec[b] = (bank_sel == BANK_BITS'(b));
        end
    end

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        for (genvar b = 0; b < BANKS; b++) begin : g_bank
            l2_sync_sram #(
                .WIDTH(WIDTH),
                .DEPTH(DEPTH)
            ) bank_i (
                .clk(clk),
                .wr_rst(wr_rst),
                .en(rd_en & bank_dec[b]),
                .we(we[w] & bank_dec[b]),
                .addr(bank_addr),
                .wdata(wdata),
                .rdata(bank_rdata[w][b])
            );
        end
    end

    // bank of the read in flight, the set may move on next cycle
    always_ff @(posedge clk) begin
        if (wr_rst) begin
            bank_q <= '0;
        end else if (rd_en) begin
            bank_q <= bank_sel;
        end
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            rdata[w] = '0;
            for (int b = 0; b < BANKS; b++) begin
                if (bank_q == BANK_BITS'(b)) begin
                    rdata[w] = bank_rdata[w][b];
                end
            end
        end
    end

    a_set_known: assert property (
        @(posedge clk) disable iff (wr_rst)
        (rd_en || (|we)) |-> !$isunknown(set_in)
    ) else $error("unknown set index on an access: %b", set_in);

endmodule

// File: src/l2_localmem.sv
/* L2 cache local memory
   line, tag, state and hprot per way plus one evict pointer per set */
`include "l2_mem_cfg.svh"

module l2_localmem (
    input  logic                      clk,
    input  logic                      wr_rst,
    input  logic                      rd_en,
    input  cache_types_pkg::set_t     set_in,
    input  cache_types_pkg::way_t     way,
    input  logic                      wr_en_line,
    input  logic                      wr_en_state,
    input  logic                      wr_en_evict_way,
    input  logic                      wr_en_put_reqs,
    input  logic                      init_all,
    input  cache_types_pkg::line_t    wr_data_line,
    input  cache_types_pkg::tag_t     wr_data_tag,
    input  cache_types_pkg::hprot_t   wr_data_hprot,
    input  cache_types_pkg::state_t   wr_data_state,
    input  cache_types_pkg::way_t     wr_data_evict_way,
    output cache_types_pkg::line_t    rd_data_line [`L2_WAYS],
    output cache_types_pkg::tag_t     rd_data_tag [`L2_WAYS],
    output cache_types_pkg::hprot_t   rd_data_hprot [`L2_WAYS],
    output cache_types_pkg::state_t   rd_data_state [`L2_WAYS],
    output cache_types_pkg::way_t     rd_data_evict_way
);

    import cache_types_pkg::*;
    import l2_bank_pkg::*;

    way_vec_t line_we;
    way_vec_t tag_we;
    way_vec_t state_we;
    way_vec_t hprot_we;
    logic     evict_we;

    logic [$bits(way_t)-1:0] evict_rd [1];

    l2_wr_decode wr_decode_i (
        .way(way),
        .wr_en_line(wr_en_line),
        .wr_en_state(wr_en_state),
        .wr_en_evict_way(wr_en_evict_way),
        .wr_en_put_reqs(wr_en_put_reqs),
        .init_all(init_all),
        .line_we(line_we),
        .tag_we(tag_we),
        .state_we(state_we),
        .hprot_we(hprot_we),
        .evict_we(evict_we)
    );

    l2_field_array #(
        .WIDTH($bits(line_t)), .WAYS(`L2_WAYS), .BANKS(LINE_BANKS)
    ) line_array_i (
        .clk(clk), .wr_rst(wr_rst), .rd_en(rd_en), .set_in(set_in),
        .we(line_we), .wdata(wr_data_line), .rdata(rd_data_line)
    );

    l2_field_array #(
        .WIDTH($bits(tag_t)), .WAYS(`L2_WAYS), .BANKS(TAG_BANKS)
    ) tag_array_i (
        .clk(clk), .wr_rst(wr_rst), .rd_en(rd_en), .set_in(set_in),
        .we(tag_we), .wdata(wr_data_tag), .rdata(rd_data_tag)
    );

    l2_field_array #(
        .WIDTH($bits(state_t)), .WAYS(`L2_WAYS), .BANKS(STATE_BANKS)
    ) state_array_i (
        .clk(clk), .wr_rst(wr_rst), .rd_en(rd_en), .set_in(set_in),
        .we(state_we), .wdata(wr_data_state), .rdata(rd_data_state)
    );

    l2_field_array #(
        .WIDTH($bits(hprot_t)), .WAYS(`L2_WAYS), .BANKS(HPROT_BANKS)
    ) hprot_array_i (
        .clk(clk), .wr_rst(wr_rst), .rd_en(rd_en), .set_in(set_in),
        .we(hprot_we), .wdata(wr_data_hprot), .rdata(rd_data_hprot)
    );

    // evict pointer is stored once per set
    l2_field_array #(
        .WIDTH($bits(way_t)), .WAYS(1), .BANKS(EVICT_BANKS)
    ) evict_array_i (
        .clk(clk), .wr_rst(wr_rst), .rd_en(rd_en), .set_in(set_in),
        .we(evict_we), .wdata(wr_data_evict_way), .rdata(evict_rd)
    );

    assign rd_data_evict_way = evict_rd[0];

endmodule

// File: src/l2_mem_cfg.svh
/* L2 local memory configuration
   way count, set index width, field widths and bank split per field */
`ifndef L2_MEM_CFG_SVH
`define L2_MEM_CFG_SVH

// associativity
`define L2_WAYS 4

// set index width, 64 sets
`define L2_SET_BITS 6

// field widths
`define L2_TAG_BITS 10
`define L2_LINE_BITS 64
`define L2_STATE_BITS 3

// banks per field, powers of two
// the bank index comes from the top set bits
`define L2_LINE_BANKS 2
`define L2_TAG_BANKS 1
`define L2_STATE_BANKS 1
`define L2_HPROT_BANKS 1
`define L2_EVICT_BANKS 1

`endif

// File: src/l2_sync_sram.sv
/* single-port synchronous RAM bank
   write at the clock edge, registered read-first output */
module l2_sync_sram #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 1 << cache_types_pkg::SET_BITS
) (
    input  logic                     clk,
    input  logic                     wr_rst,
    input  logic                     en,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic [WIDTH-1:0]         wdata,
    output logic [WIDTH-1:0]         rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
    end

    // old word on a same-edge write, held between reads
    always_ff @(posedge clk) begin
        if (wr_rst) begin
            rdata <= '0;
        end else if (en) begin
            rdata <= mem[addr];
        end
    end

    a_addr_range: assert property (
        @(posedge clk) disable iff (wr_rst)
        (en || we) |-> (int'(addr) < DEPTH)
    ) else $error("sram access outside depth, addr %0d", addr);

endmodule

// File: src/l2_wr_decode.sv
/* write enable decoder
   way select and field enables into per-way write vectors */
module l2_wr_decode (
    input  cache_types_pkg::way_t     way,
    input  logic                      wr_en_line,
    input  logic                      wr_en_state,
    input  logic                      wr_en_evict_way,
    input  logic                      wr_en_put_reqs,
    input  logic                      init_all,
    output cache_types_pkg::way_vec_t line_we,
    output cache_types_pkg::way_vec_t tag_we,
    output cache_types_pkg::way_vec_t state_we,
    output cache_types_pkg::way_vec_t hprot_we,
    output logic                      evict_we
);

    import cache_types_pkg::*;

    way_vec_t way_sel;
    logic     line_en;
    logic     state_en;

    // init_all reaches every way of the set
    always_comb begin
        way_sel = '0;
        if (init_all) begin
            way_sel = '1;
        end else begin
            way_sel[way] = 1'b1;
        end
    end

    assign line_en = wr_en_line | wr_en_put_reqs;
    assign state_en = wr_en_state | wr_en_put_reqs | init_all;

    assign line_we = line_en ? way_sel : '0;
    assign state_we = state_en ? way_sel : '0;

    // a put request fills the whole way
    assign tag_we = wr_en_put_reqs ? way_sel : '0;
    assign hprot_we = wr_en_put_reqs ? way_sel : '0;

    // one pointer per set, shared by all ways
    assign evict_we = wr_en_evict_way;

    // a put under init_all would spread one way's tag over the set
    always_comb begin
        a_put_vs_init: assert (!(wr_en_put_reqs && init_all))
        else $error("put request and init_all in the same cycle");
    end

endmodule
